//--- hdl/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// instruction word width
`define EXU_ILEN 32

// datapath width
`define EXU_XLEN 32

// interrupt vector base out of reset
`define EXU_VECT_RESET 32'hffffffc0

// multiplier iterations, one 8-bit slice of b per step
`define EXU_MUL_STEPS 4

`endif

//--- hdl/exu_pkg.sv
package exu_pkg;

  // instruction class, ir[31:28]
  typedef enum logic [3:0] {
    C_ALU    = 4'h0,
    C_MUL    = 4'h1,
    C_CMP    = 4'h2,
    C_BRANCH = 4'h3,
    C_JUMP   = 4'h4,
    C_LDI    = 4'h5,
    C_MOV    = 4'h6,
    C_INH    = 4'h7
  } instr_class_t;

  // alu op, taken from op[2:0] for the alu class
  typedef enum logic [2:0] {
    ALU_ADD = 3'h0,
    ALU_SUB = 3'h1,
    ALU_AND = 3'h2,
    ALU_OR  = 3'h3,
    ALU_XOR = 3'h4,
    ALU_SHL = 3'h5,
    ALU_SHR = 3'h6,
    ALU_ASR = 3'h7
  } alu_func_t;

  // which half of the 64-bit product
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HI = 1'b1
  } mul_func_t;

endpackage

//--- hdl/exu_decode.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_decode (
  input  logic [`EXU_ILEN-1:0]  ir_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  input  logic [`EXU_XLEN-1:0]  reg_data1_i,
  input  logic [`EXU_XLEN-1:0]  reg_data2_i,
  output exu_pkg::instr_class_t cls_o,
  output logic [3:0]            op_o,
  output exu_pkg::alu_func_t    alu_func_o,
  output logic [`EXU_XLEN-1:0]  alu_a_o,
  output logic [`EXU_XLEN-1:0]  alu_b_o,
  output exu_pkg::mul_func_t    mul_func_o,
  output logic                  mul_req_o,
  output logic [`EXU_XLEN-1:0]  imm_o
);
  import exu_pkg::*;

  logic [15:0]          imm16;
  logic [`EXU_XLEN-1:0] imm_sx;
  logic [`EXU_XLEN-1:0] imm_zx;

  assign cls_o  = instr_class_t'(ir_i[31:28]);
  assign op_o   = ir_i[27:24];
  assign imm16  = ir_i[15:0];
  assign imm_sx = {{(`EXU_XLEN-16){imm16[15]}}, imm16};
  assign imm_zx = {{(`EXU_XLEN-16){1'b0}}, imm16};

  assign imm_o = (cls_o == C_LDI) ? imm_zx : imm_sx;  // ldi is unsigned

  assign mul_req_o  = (cls_o == C_MUL);
  assign mul_func_o = mul_func_t'(op_o[0]);

  always_comb
  begin
    alu_func_o = ALU_ADD;
    alu_a_o    = reg_data1_i;
    alu_b_o    = reg_data2_i;
    case (cls_o)
      C_ALU:
      begin
        alu_func_o = alu_func_t'(op_o[2:0]);
        if (op_o[3])
          alu_b_o = imm_sx;  // immediate form
      end
      C_CMP:
        alu_func_o = ALU_SUB;
      C_BRANCH:
      begin
        // word offset from the branch pc
        alu_a_o = pc_i;
        alu_b_o = {imm_sx[`EXU_XLEN-3:0], 2'b00};
      end
      C_JUMP:
        alu_b_o = imm_sx;  // rs1 + imm16
      default:
        alu_func_o = ALU_ADD;
    endcase
  end

endmodule

//--- hdl/exu_alu.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_func_t   func_i,
  output logic [`EXU_XLEN-1:0] y_o,
  output logic                 c_o,
  output logic                 n_o,
  output logic                 v_o,
  output logic                 z_o
);
  import exu_pkg::*;

  localparam int MSB = `EXU_XLEN - 1;
  localparam int SW  = $clog2(`EXU_XLEN);

  logic [`EXU_XLEN:0] sum;
  logic [`EXU_XLEN:0] diff;
  logic [SW-1:0]      shamt;

  assign sum   = {1'b0, a_i} + {1'b0, b_i};
  assign diff  = {1'b0, a_i} - {1'b0, b_i};
  assign shamt = b_i[SW-1:0];

  always_comb
  begin
    c_o = 1'b0;
    v_o = 1'b0;
    case (func_i)
      ALU_ADD:
      begin
        y_o = sum[MSB:0];
        c_o = sum[`EXU_XLEN];
        v_o = (a_i[MSB] == b_i[MSB]) && (y_o[MSB] != a_i[MSB]);
      end
      ALU_SUB:
      begin
        y_o = diff[MSB:0];
        c_o = diff[`EXU_XLEN];  // set when a < b unsigned
        v_o = (a_i[MSB] != b_i[MSB]) && (y_o[MSB] != a_i[MSB]);
      end
      ALU_AND: y_o = a_i & b_i;
      ALU_OR:  y_o = a_i | b_i;
      ALU_XOR: y_o = a_i ^ b_i;
      ALU_SHL: y_o = a_i << shamt;
      ALU_SHR: y_o = a_i >> shamt;
      ALU_ASR: y_o = $signed(a_i) >>> shamt;
      default: y_o = a_i;
    endcase
    n_o = y_o[MSB];
    z_o = ~|y_o;
  end

endmodule

//--- hdl/exu_intcalc.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_intcalc (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::mul_func_t   func_i,
  output logic                 busy_o,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] y_o
);
  import exu_pkg::*;

  localparam int SLICE = `EXU_XLEN / `EXU_MUL_STEPS;
  localparam int PW    = 2 * `EXU_XLEN;
  localparam int CW    = $clog2(`EXU_MUL_STEPS);

  logic [PW-1:0]        acc;    // partial product
  logic [PW-1:0]        a_sh;   // a aligned to the next slice
  logic [`EXU_XLEN-1:0] b_rem;  // remaining slices of b
  logic [CW-1:0]        step;
  logic                 last;
  mul_func_t            func_q;

  assign last = (step == CW'(`EXU_MUL_STEPS - 1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      step   <= '0;
    end
    else if (start_i)
    begin
      busy_o <= 1'b1;
      step   <= CW'(1);  // slice 0 is taken at start
    end
    else if (done_o)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end
    else if (busy_o)
    begin
      step   <= step + 1'b1;
      done_o <= last;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      acc    <= PW'(a_i) * PW'(b_i[SLICE-1:0]);
      a_sh   <= PW'(a_i) << SLICE;
      b_rem  <= b_i >> SLICE;
      func_q <= func_i;
    end
    else if (busy_o && !done_o)
    begin
      acc   <= acc + a_sh * PW'(b_rem[SLICE-1:0]);
      a_sh  <= a_sh << SLICE;
      b_rem <= b_rem >> SLICE;
    end
  end

  assign y_o = (func_q == MUL_HI) ? acc[PW-1:`EXU_XLEN] : acc[`EXU_XLEN-1:0];

  a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> !busy_o);

  a_done_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> ##(`EXU_MUL_STEPS) done_o);

endmodule

//--- hdl/exu_stage.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic [`EXU_ILEN-1:0]  ir_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  input  logic [`EXU_XLEN-1:0]  reg_data1_i,
  input  logic                  reg_write_i,
  input  logic [2:0]            irq_i,
  input  logic                  stall_i,
  input  exu_pkg::instr_class_t cls_i,
  input  logic [3:0]            op_i,
  input  logic [`EXU_XLEN-1:0]  imm_i,
  input  logic [`EXU_XLEN-1:0]  alu_y_i,
  input  logic                  alu_c_i,
  input  logic                  alu_n_i,
  input  logic                  alu_v_i,
  input  logic                  alu_z_i,
  input  logic                  mul_req_i,
  input  logic                  mul_done_i,
  input  logic [`EXU_XLEN-1:0]  mul_y_i,
  output logic                  mul_start_o,
  output logic                  valid_o,
  output logic [`EXU_ILEN-1:0]  ir_o,
  output logic [`EXU_XLEN-1:0]  result_o,
  output logic                  reg_write_o,
  output logic [2:0]            ccr_o,
  output logic [`EXU_XLEN-1:0]  pc_o,
  output logic                  pc_set_o,
  output logic                  halt_o,
  output logic                  exc_o,
  output logic                  int_en_o,
  output logic                  stall_o
);
  import exu_pkg::*;

  logic                 irq_take;
  logic                 accept;
  logic                 mul_run;   // multiplier started and not yet done
  logic                 mul_have;  // product parked while downstream stalls
  logic [`EXU_XLEN-1:0] mul_res;
  logic                 mul_ready;
  logic                 mul_wait;
  logic                 taken;
  logic [`EXU_XLEN-1:0] result_d;
  logic [`EXU_XLEN-1:0] pc_d;
  logic                 pc_set_d;
  logic                 reg_write_d;
  logic [2:0]           ccr_d;
  logic                 int_en_d;
  logic                 halt_d;

  // no interrupt entry once a multiply has started
  assign irq_take    = valid_i && (irq_i != 3'h0) && int_en_o && !mul_run && !mul_have;
  assign mul_ready   = mul_done_i || mul_have;
  assign mul_wait    = valid_i && mul_req_i && !irq_take && !mul_ready;
  assign stall_o     = stall_i || mul_wait;
  assign accept      = valid_i && !stall_o;
  assign mul_start_o = mul_wait && !mul_run;

  // ccr_o = {ltu, lt, eq}
  always_comb
  begin
    case (op_i)
      4'h0:    taken = 1'b1;                      // bra
      4'h1:    taken = ccr_o[0];                  // beq
      4'h2:    taken = !ccr_o[0];                 // bne
      4'h3:    taken = !(ccr_o[2] || ccr_o[0]);   // bgtu
      4'h4:    taken = !(ccr_o[1] || ccr_o[0]);   // bgt
      4'h5:    taken = !ccr_o[1];                 // bge
      4'h6:    taken = ccr_o[1] || ccr_o[0];      // ble
      4'h7:    taken = ccr_o[1];                  // blt
      4'h8:    taken = !ccr_o[2];                 // bgeu
      4'h9:    taken = ccr_o[2];                  // bltu
      4'ha:    taken = ccr_o[2] || ccr_o[0];      // bleu
      default: taken = 1'b0;
    endcase
  end

  always_comb
  begin
    result_d    = alu_y_i;
    pc_d        = pc_i;
    pc_set_d    = 1'b0;
    reg_write_d = reg_write_i;
    ccr_d       = ccr_o;
    int_en_d    = int_en_o;
    halt_d      = halt_o;
    if (irq_take)
    begin
      result_d    = `EXU_VECT_RESET + {{(`EXU_XLEN-6){1'b0}}, irq_i, 3'b000};
      pc_set_d    = 1'b1;
      reg_write_d = 1'b0;
      int_en_d    = 1'b0;
    end
    else
    begin
      case (cls_i)
        C_MUL:
          result_d = mul_have ? mul_res : mul_y_i;
        C_CMP:
          ccr_d = {alu_c_i, alu_n_i ^ alu_v_i, alu_z_i};
        C_BRANCH:
        begin
          pc_set_d = taken;
          if (taken)
            pc_d = alu_y_i;
        end
        C_JUMP:
        begin
          pc_d     = alu_y_i;
          pc_set_d = 1'b1;
        end
        C_LDI:
          result_d = imm_i;
        C_MOV:
        begin
          result_d = reg_data1_i;
          if (op_i == 4'h0)
            result_d = {{(`EXU_XLEN-3){1'b0}}, ccr_o};
          else if (op_i == 4'h4)
            ccr_d = reg_data1_i[2:0];
        end
        C_INH:
        begin
          if (op_i == 4'h2)
            int_en_d = 1'b0;          // cli
          else if (op_i == 4'h3)
            int_en_d = !halt_o;       // sti
          else if (op_i == 4'h4)
          begin
            halt_d   = 1'b1;
            int_en_d = 1'b0;
          end
        end
        default:
          result_d = alu_y_i;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      valid_o     <= 1'b0;
      pc_set_o    <= 1'b0;
      reg_write_o <= 1'b0;
      halt_o      <= 1'b0;
      exc_o       <= 1'b0;
      int_en_o    <= 1'b0;
      ccr_o       <= 3'h0;
      mul_run     <= 1'b0;
      mul_have    <= 1'b0;
    end
    else
    begin
      if (!stall_i)
      begin
        valid_o  <= accept;
        pc_set_o <= accept && pc_set_d;  // one redirect per instruction
      end
      if (accept)
      begin
        reg_write_o <= reg_write_d;
        exc_o       <= irq_take;
        ccr_o       <= ccr_d;
        int_en_o    <= int_en_d;
        halt_o      <= halt_d;
      end
      if (mul_start_o)
        mul_run <= 1'b1;
      else if (mul_done_i)
        mul_run <= 1'b0;
      if (accept)
        mul_have <= 1'b0;
      else if (mul_done_i)
        mul_have <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      ir_o     <= ir_i;
      result_o <= result_d;
      pc_o     <= pc_d;
    end
    if (mul_done_i)
      mul_res <= mul_y_i;
  end

  a_no_redirect_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_i |=> !$rose(pc_set_o) && !$rose(exc_o));

endmodule

//--- hdl/exu_top.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module exu_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic [`EXU_ILEN-1:0] ir_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] reg_data1_i,
  input  logic [`EXU_XLEN-1:0] reg_data2_i,
  input  logic                 reg_write_i,
  input  logic [2:0]           irq_i,
  input  logic                 stall_i,
  output logic                 valid_o,
  output logic [`EXU_ILEN-1:0] ir_o,
  output logic [`EXU_XLEN-1:0] result_o,
  output logic                 reg_write_o,
  output logic [2:0]           ccr_o,
  output logic [`EXU_XLEN-1:0] pc_o,
  output logic                 pc_set_o,
  output logic                 halt_o,
  output logic                 exc_o,
  output logic                 stall_o,
  output logic                 int_en_o
);
  import exu_pkg::*;

  instr_class_t         cls;
  logic [3:0]           op;
  alu_func_t            alu_func;
  logic [`EXU_XLEN-1:0] alu_a;
  logic [`EXU_XLEN-1:0] alu_b;
  logic [`EXU_XLEN-1:0] alu_y;
  logic                 alu_c;
  logic                 alu_n;
  logic                 alu_v;
  logic                 alu_z;
  mul_func_t            mul_func;
  logic                 mul_req;
  logic                 mul_start;
  logic                 mul_done;
  logic [`EXU_XLEN-1:0] mul_y;
  logic [`EXU_XLEN-1:0] imm;

  exu_decode exu_decode_inst (
    .ir_i        (ir_i),
    .pc_i        (pc_i),
    .reg_data1_i (reg_data1_i),
    .reg_data2_i (reg_data2_i),
    .cls_o       (cls),
    .op_o        (op),
    .alu_func_o  (alu_func),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b),
    .mul_func_o  (mul_func),
    .mul_req_o   (mul_req),
    .imm_o       (imm)
  );

  exu_alu exu_alu_inst (
    .a_i    (alu_a),
    .b_i    (alu_b),
    .func_i (alu_func),
    .y_o    (alu_y),
    .c_o    (alu_c),
    .n_o    (alu_n),
    .v_o    (alu_v),
    .z_o    (alu_z)
  );

  // multiplier shares the alu operand path
  exu_intcalc exu_intcalc_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (mul_start),
    .a_i     (alu_a),
    .b_i     (alu_b),
    .func_i  (mul_func),
    .busy_o  (),
    .done_o  (mul_done),
    .y_o     (mul_y)
  );

  exu_stage exu_stage_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .ir_i        (ir_i),
    .pc_i        (pc_i),
    .reg_data1_i (reg_data1_i),
    .reg_write_i (reg_write_i),
    .irq_i       (irq_i),
    .stall_i     (stall_i),
    .cls_i       (cls),
    .op_i        (op),
    .imm_i       (imm),
    .alu_y_i     (alu_y),
    .alu_c_i     (alu_c),
    .alu_n_i     (alu_n),
    .alu_v_i     (alu_v),
    .alu_z_i     (alu_z),
    .mul_req_i   (mul_req),
    .mul_done_i  (mul_done),
    .mul_y_i     (mul_y),
    .mul_start_o (mul_start),
    .valid_o     (valid_o),
    .ir_o        (ir_o),
    .result_o    (result_o),
    .reg_write_o (reg_write_o),
    .ccr_o       (ccr_o),
    .pc_o        (pc_o),
    .pc_set_o    (pc_set_o),
    .halt_o      (halt_o),
    .exc_o       (exc_o),
    .int_en_o    (int_en_o),
    .stall_o     (stall_o)
  );

endmodule

//--- test/exu_ref_model.svh
function automatic logic [31:0] sext16(input logic [15:0] v);
  return {{16{v[15]}}, v};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f, input logic [31:0] a,
                                        input logic [31:0] b);
  case (f)
    3'h0:    return a + b;
    3'h1:    return a - b;
    3'h2:    return a & b;
    3'h3:    return a | b;
    3'h4:    return a ^ b;
    3'h5:    return a << b[4:0];
    3'h6:    return a >> b[4:0];
    default: return $unsigned($signed(a) >>> b[4:0]);
  endcase
endfunction

function automatic logic [31:0] mul_ref(input logic hi, input logic [31:0] a,
                                        input logic [31:0] b);
  logic [63:0] p;
  p = {32'h0, a} * {32'h0, b};
  return hi ? p[63:32] : p[31:0];
endfunction

// {ltu, lt, eq}
function automatic logic [2:0] ccr_cmp(input logic [31:0] a, input logic [31:0] b);
  return {a < b, $signed(a) < $signed(b), a == b};
endfunction

function automatic logic branch_taken(input logic [3:0] cond, input logic [2:0] ccr);
  logic ltu;
  logic lt;
  logic eq;
  ltu = ccr[2];
  lt  = ccr[1];
  eq  = ccr[0];
  case (cond)
    4'h0:    return 1'b1;
    4'h1:    return eq;
    4'h2:    return !eq;
    4'h3:    return !ltu && !eq;
    4'h4:    return !lt && !eq;
    4'h5:    return !lt;
    4'h6:    return lt || eq;
    4'h7:    return lt;
    4'h8:    return !ltu;
    4'h9:    return ltu;
    4'ha:    return ltu || eq;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [31:0] vector_ref(input logic [2:0] irq);
  return `EXU_VECT_RESET + {26'h0, irq, 3'b000};
endfunction

// result for every class except inherent ops
function automatic logic [31:0] result_ref(input logic [31:0] ir, input logic [31:0] pc,
                                           input logic [31:0] r1, input logic [31:0] r2,
                                           input logic [2:0] ccr);
  logic [3:0] op;
  op = ir[27:24];
  case (ir[31:28])
    4'h0:    return alu_ref(op[2:0], r1, op[3] ? sext16(ir[15:0]) : r2);
    4'h1:    return mul_ref(op[0], r1, r2);
    4'h2:    return r1 - r2;
    4'h3:    return pc + (sext16(ir[15:0]) << 2);
    4'h4:    return r1 + sext16(ir[15:0]);
    4'h5:    return {16'h0, ir[15:0]};
    4'h6:    return (op == 4'h0) ? {29'h0, ccr} : r1;
    default: return r1 + r2;
  endcase
endfunction

//--- test/tb_exu.sv
`timescale 1ns/1ps
`include "exu_macros.svh"

module tb_exu;
  import exu_pkg::*;

  localparam int NUM_INSTR   = 2000;
  localparam int WATCHDOG_NS = NUM_INSTR * 6 * 20;

  typedef struct {
    logic        valid;
    logic [31:0] ir;
    logic [31:0] result;
    logic [31:0] pc;
    logic        chk_result;
    logic        reg_write;
    logic        pc_set;
    logic        exc;
    logic        int_en;
    logic        halt;
    logic [2:0]  ccr;
  } exp_t;

  logic        clk_i;
  logic        rst_i;
  logic        valid_i;
  logic [31:0] ir_i;
  logic [31:0] pc_i;
  logic [31:0] reg_data1_i;
  logic [31:0] reg_data2_i;
  logic        reg_write_i;
  logic [2:0]  irq_i;
  logic        stall_i;
  logic        valid_o;
  logic [31:0] ir_o;
  logic [31:0] result_o;
  logic        reg_write_o;
  logic [2:0]  ccr_o;
  logic [31:0] pc_o;
  logic        pc_set_o;
  logic        halt_o;
  logic        exc_o;
  logic        stall_o;
  logic        int_en_o;

  logic [31:0] lcg_state = 32'h17c6_8730;
  logic [2:0]  m_ccr;  // model copy of the condition codes
  logic        m_int_en;
  logic        m_halt;
  exp_t        exp_q[$];
  exp_t        head;
  exp_t        snap;
  logic        checking;
  logic        pend;
  logic        prev_stall;
  int          value_errors;
  int          other_errors;

  `include "exu_ref_model.svh"

  exu_top exu_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .ir_i        (ir_i),
    .pc_i        (pc_i),
    .reg_data1_i (reg_data1_i),
    .reg_data2_i (reg_data2_i),
    .reg_write_i (reg_write_i),
    .irq_i       (irq_i),
    .stall_i     (stall_i),
    .valid_o     (valid_o),
    .ir_o        (ir_o),
    .result_o    (result_o),
    .reg_write_o (reg_write_o),
    .ccr_o       (ccr_o),
    .pc_o        (pc_o),
    .pc_set_o    (pc_set_o),
    .halt_o      (halt_o),
    .exc_o       (exc_o),
    .stall_o     (stall_o),
    .int_en_o    (int_en_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    check_bit("valid_o", valid_o, e.valid);
    check_value("ir_o", ir_o, e.ir);
    if (e.chk_result)
      check_value("result_o", result_o, e.result);
    check_value("pc_o", pc_o, e.pc);
    check_bit("reg_write_o", reg_write_o, e.reg_write);
    check_bit("pc_set_o", pc_set_o, e.pc_set);
    check_bit("exc_o", exc_o, e.exc);
    check_bit("int_en_o", int_en_o, e.int_en);
    check_bit("halt_o", halt_o, e.halt);
    check_value("ccr_o", {29'h0, ccr_o}, {29'h0, e.ccr});
  endtask

  function automatic exp_t sample_outputs();
    exp_t s;
    s.valid      = valid_o;
    s.ir         = ir_o;
    s.result     = result_o;
    s.pc         = pc_o;
    s.chk_result = 1'b1;
    s.reg_write  = reg_write_o;
    s.pc_set     = pc_set_o;
    s.exc        = exc_o;
    s.int_en     = int_en_o;
    s.halt       = halt_o;
    s.ccr        = ccr_o;
    return s;
  endfunction

  // expected outputs for the instruction accepted at the coming edge
  task automatic predict();
    exp_t       e;
    logic [3:0] op;
    op          = ir_i[27:24];
    e.valid     = 1'b1;
    e.ir        = ir_i;
    e.pc        = pc_i;
    e.pc_set    = 1'b0;
    e.reg_write = reg_write_i;
    e.exc       = 1'b0;
    e.chk_result = 1'b1;
    if (irq_i != 3'h0 && m_int_en)
    begin
      e.result    = vector_ref(irq_i);
      e.pc_set    = 1'b1;
      e.reg_write = 1'b0;
      e.exc       = 1'b1;
      m_int_en    = 1'b0;
    end
    else
    begin
      e.result = result_ref(ir_i, pc_i, reg_data1_i, reg_data2_i, m_ccr);
      case (instr_class_t'(ir_i[31:28]))
        C_CMP:
          m_ccr = ccr_cmp(reg_data1_i, reg_data2_i);
        C_BRANCH:
        begin
          if (branch_taken(op, m_ccr))
          begin
            e.pc_set = 1'b1;
            e.pc     = e.result;
          end
        end
        C_JUMP:
        begin
          e.pc_set = 1'b1;
          e.pc     = e.result;
        end
        C_MOV:
          if (op == 4'h4)
            m_ccr = reg_data1_i[2:0];
        C_INH:
        begin
          e.chk_result = 1'b0;
          if (op == 4'h2)
            m_int_en = 1'b0;
          else if (op == 4'h3)
            m_int_en = !m_halt;
          else if (op == 4'h4)
          begin
            m_halt   = 1'b1;
            m_int_en = 1'b0;
          end
        end
        default: ;
      endcase
    end
    e.ccr    = m_ccr;
    e.int_en = m_int_en;
    e.halt   = m_halt;
    exp_q.push_back(e);
  endtask

  // checker samples mid-cycle where everything is settled
  always @(negedge clk_i)
  begin
    if (!checking)
    begin
      pend       = 1'b0;
      prev_stall = 1'b0;
    end
    else
    begin
      if (pend)
      begin
        head = exp_q.pop_front();
        compare_outputs(head);
      end
      else if (prev_stall)
        compare_outputs(snap);  // held through downstream stall
      else
      begin
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("pc_set_o", pc_set_o, 1'b0);
      end
      snap       = sample_outputs();
      prev_stall = stall_i;
      pend       = valid_i && !stall_o;
      if (pend)
        predict();
    end
  end

  task automatic send(input logic [31:0] ir, input logic [31:0] r1, input logic [31:0] r2,
                      input logic [2:0] irq, input int stall_len);
    int          cycles;
    int          exp_cycles;
    int          left;
    logic        acc;
    logic [31:0] r;
    r          = lcg_next();
    exp_cycles = (ir[31:28] == C_MUL && !(irq != 3'h0 && m_int_en)) ? 5 : 1;
    cycles     = 0;
    left       = stall_len;
    acc        = 1'b0;
    valid_i     = 1'b1;
    ir_i        = ir;
    pc_i        = {r[31:2], 2'b00};
    reg_data1_i = r1;
    reg_data2_i = r2;
    reg_write_i = r[0];
    irq_i       = irq;
    stall_i     = (left > 0);
    while (!acc)
    begin
      @(negedge clk_i);
      acc = valid_i && !stall_o;
      @(posedge clk_i);
      #2;
      cycles++;
      if (left > 0)
        left--;
      stall_i = (left > 0);
    end
    valid_i = 1'b0;
    irq_i   = 3'h0;
    if (stall_len == 0 && cycles != exp_cycles)
    begin
      other_errors++;
      $display("instruction %h was accepted after %0d cycles instead of %0d",
               ir, cycles, exp_cycles);
    end
  endtask

  task automatic send_op(input logic [3:0] cls, input logic [3:0] op, input logic [2:0] irq,
                         input int stall_len);
    logic [31:0] r;
    r = lcg_next();
    send({cls, op, r[23:0]}, lcg_next(), lcg_next(), irq, stall_len);
  endtask

  function automatic int pick_stall();
    logic [31:0] r;
    r = lcg_next();
    return (r[10:8] < 3'd3) ? int'(r[14:12]) + 1 : 0;
  endfunction

  task automatic idle_maybe();
    logic [31:0] r;
    r = lcg_next();
    if (r[4:2] == 3'h0)
    begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    @(posedge clk_i);
    #2;
    checking = 1'b0;
    valid_i  = 1'b0;
    stall_i  = 1'b0;
    rst_i    = 1'b1;
    repeat (3) @(posedge clk_i);
    #2;
    rst_i    = 1'b0;
    m_ccr    = 3'h0;
    m_int_en = 1'b0;
    m_halt   = 1'b0;
    exp_q.delete();
    if (valid_o !== 1'b0 || pc_set_o !== 1'b0 || halt_o !== 1'b0 || exc_o !== 1'b0 ||
        int_en_o !== 1'b0 || stall_o !== 1'b0 || ccr_o !== 3'h0)
    begin
      other_errors++;
      $display("control outputs are not inactive after reset");
    end
    checking = 1'b1;
  endtask

  initial
  begin
    #WATCHDOG_NS;
    $display("watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    logic [31:0] r;
    logic [31:0] a;
    logic [3:0]  cls;
    rst_i        = 1'b1;
    valid_i      = 1'b0;
    ir_i         = '0;
    pc_i         = '0;
    reg_data1_i  = '0;
    reg_data2_i  = '0;
    reg_write_i  = 1'b0;
    irq_i        = 3'h0;
    stall_i      = 1'b0;
    checking     = 1'b0;
    value_errors = 0;
    other_errors = 0;
    apply_reset();

    // alu, ldi and mov
    repeat (500)
    begin
      r = lcg_next();
      cls = (r[1:0] == 2'h0) ? C_LDI : (r[1:0] == 2'h1) ? C_MOV : C_ALU;
      send_op(cls, r[7:4], 3'h0, 0);
      idle_maybe();
    end

    // compare then branch with some jumps
    repeat (250)
    begin
      r = lcg_next();
      a = lcg_next();
      send({C_CMP, 4'h0, r[23:0]}, a, r[8] ? a : lcg_next(), 3'h0, 0);
      send_op(C_BRANCH, r[31:28], 3'h0, 0);
      if (r[10:9] == 2'h0)
        send_op(C_JUMP, 4'h0, 3'h0, 0);
    end

    repeat (150)
    begin
      r = lcg_next();
      send_op(C_MUL, {3'h0, r[31]}, 3'h0, 0);
    end

    // interrupts with sti and cli mixed in
    send_op(C_INH, 4'h3, 3'h0, 0);
    send_op(C_ALU, 4'h0, 3'h5, 0);
    send_op(C_INH, 4'h2, 3'h0, 0);
    send_op(C_ALU, 4'h0, 3'h7, 0);
    repeat (200)
    begin
      r = lcg_next();
      if (r[3:0] == 4'h0)
        send_op(C_INH, 4'h2, 3'h0, 0);
      else if (r[3:0] < 4'h4)
        send_op(C_INH, 4'h3, 3'h0, 0);
      else
        send_op({2'b0, r[5:4]}, r[11:8], r[14] ? r[18:16] : 3'h0, 0);
    end

    // downstream stall over a mix of classes
    repeat (300)
    begin
      r = lcg_next();
      cls = (r[2:0] == 3'h7) ? C_ALU : {1'b0, r[2:0]};
      send_op(cls, r[7:4], 3'h0, pick_stall());
      idle_maybe();
    end

    // halt is sticky until reset
    send_op(C_INH, 4'h4, 3'h0, 0);
    send_op(C_INH, 4'h3, 3'h0, 0);
    repeat (20)
      send_op(C_ALU, 4'h0, 3'h3, 0);
    @(negedge clk_i);
    if (halt_o !== 1'b1 || int_en_o !== 1'b0)
    begin
      other_errors++;
      $display("halt_o or int_en_o wrong after halt");
    end
    apply_reset();
    repeat (20)
      send_op(C_ALU, 4'h0, 3'h0, 0);
    @(negedge clk_i);
    @(negedge clk_i);

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- exu.f
+incdir+hdl
+incdir+test
hdl/exu_pkg.sv
hdl/exu_decode.sv
hdl/exu_alu.sv
hdl/exu_intcalc.sv
hdl/exu_stage.sv
hdl/exu_top.sv
test/tb_exu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exu.f --top-module tb_exu -o tb_exu_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_exu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
